//--- Makefile
# Verilator build and run for the stream pipe
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_stream_pipe
RTL_TOP   ?= stream_pipe_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# The run fails on a non-zero exit or when the log holds the fail message
run: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/csr_axil.sv
/*
 * AXI4-Lite register block
 *   - Control (enable, clear_counters) and offset registers
 *   - Read-only view of the beat and packet counters
 *   - SLVERR for unaligned or unmapped addresses
 */

`timescale 1ns/1ps

module csr_axil
  import flow_pkg::*;
  import csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,

  input  axil_req_t             axil_req,
  output axil_rsp_t             axil_rsp,

  output ctrl_t                 ctrl,
  output logic [data_width-1:0] offset,
  input  logic [data_width-1:0] beat_count,
  input  logic [data_width-1:0] pkt_count
);

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------

  // Word aligned and no higher than the last register
  function automatic logic addr_ok(input logic [axil_addr_width-1:0] addr);
    logic ok;
    ok = (addr[1:0] == 2'b00) && (addr <= reg_pkt_count);
    return ok;
  endfunction

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------

  logic       wr_accept;
  logic       wr_ok;
  logic       bvalid_q;
  logic [1:0] bresp_q;
  logic       enable_q;

  // Address and data are taken in the same cycle, never one alone,
  // and only once the previous write response has been taken
  assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign wr_ok     = addr_ok(axil_req.awaddr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid_q <= 1'b0;
      enable_q <= 1'b0;
      offset   <= '0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      // Writes to the counters fall through and change nothing
      if (wr_accept && wr_ok) begin
        case (axil_req.awaddr)
          reg_ctrl:   enable_q <= axil_req.wdata[0];
          reg_offset: offset   <= axil_req.wdata[data_width-1:0];
          default:    ;
        endcase
      end
    end
  end

  // Response code of the write taken at the accept
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp_q <= wr_ok ? resp_okay : resp_slverr;
    end
  end

  // Clear is a pulse on the accept cycle itself, so the counters
  // are zeroed at the same edge that commits the write
  assign ctrl.enable         = enable_q;
  assign ctrl.clear_counters = wr_accept && (axil_req.awaddr == reg_ctrl) &&
                               axil_req.wdata[1];

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------

  logic                       rd_accept;
  logic                       rvalid_q;
  logic [axil_data_width-1:0] rdata_d;
  logic [axil_data_width-1:0] rdata_q;
  logic [1:0]                 rresp_q;

  // One read in flight at a time
  assign rd_accept = axil_req.arvalid && !rvalid_q;

  // Read mux where clear_counters reads back as zero
  // Unmapped and unaligned addresses match no entry and read zero
  always_comb begin
    rdata_d = '0;
    case (axil_req.araddr)
      reg_ctrl:       rdata_d[0] = enable_q;
      reg_offset:     rdata_d    = offset;
      reg_beat_count: rdata_d    = beat_count;
      reg_pkt_count:  rdata_d    = pkt_count;
      default:        rdata_d    = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Data is captured at the accept and held until rready
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_q <= rdata_d;
      rresp_q <= addr_ok(axil_req.araddr) ? resp_okay : resp_slverr;
    end
  end

  // --------------------------------------------------
  // Response bundle
  // --------------------------------------------------

  always_comb begin
    axil_rsp.awready = wr_accept;
    axil_rsp.wready  = wr_accept;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = !rvalid_q;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule : csr_axil

//--- design/csr_pkg.sv
/*
 * Register port definitions
 *   - AXI4-Lite address and data widths
 *   - Request and response structs of the register port
 *   - Register map offsets, response codes and the control struct
 */

package csr_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------

  // Byte address, enough for the four word registers
  localparam int axil_addr_width = 8;
  localparam int axil_data_width = 32;

  // --------------------------------------------------
  // AXI4-Lite channels
  // --------------------------------------------------

  // Master to slave, write strobes and protection are not carried
  typedef struct packed {
    logic                       awvalid;
    logic [axil_addr_width-1:0] awaddr;
    logic                       wvalid;
    logic [axil_data_width-1:0] wdata;
    logic                       bready;
    logic                       arvalid;
    logic [axil_addr_width-1:0] araddr;
    logic                       rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    logic [1:0]                 bresp;
    logic                       arready;
    logic                       rvalid;
    logic [axil_data_width-1:0] rdata;
    logic [1:0]                 rresp;
  } axil_rsp_t;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------

  localparam logic [axil_addr_width-1:0] reg_ctrl       = 8'h00;
  localparam logic [axil_addr_width-1:0] reg_offset     = 8'h04;
  localparam logic [axil_addr_width-1:0] reg_beat_count = 8'h08;
  localparam logic [axil_addr_width-1:0] reg_pkt_count  = 8'h0C;

  // Response codes on bresp and rresp
  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

  // Control word, enable sits in bit 0 and clear_counters in bit 1
  typedef struct packed {
    logic clear_counters;
    logic enable;
  } ctrl_t;

endpackage : csr_pkg

//--- design/flow_pkg.sv
/*
 * Stream datapath definitions
 *   - data_width    : width of one stream word
 *   - stream_beat_t : payload of one beat, data word plus last flag
 */

package flow_pkg;

  // --------------------------------------------------
  // Stream word
  // --------------------------------------------------

  // Every stage of the pipe carries words of this width
  localparam int data_width = 32;

  // --------------------------------------------------
  // Beat payload
  // --------------------------------------------------

  // One transfer on a valid/ready link
  // The last flag marks the final beat of a packet and is carried
  // through the pipe untouched
  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  last;
  } stream_beat_t;

endpackage : flow_pkg

//--- design/flow_reg_fwd.sv
/*
 * Forward-registered flow register
 *   - pop_valid and pop_data come straight from flops
 *   - push_ready passes back-pressure through without delay
 *   - One cycle of cut-through latency, one beat per cycle steady state
 */

`timescale 1ns/1ps

module flow_reg_fwd #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,

  output logic     push_ready,
  input  logic     push_valid,
  input  payload_t push_data,

  input  logic     pop_ready,
  output logic     pop_valid,
  output payload_t pop_data
);

  // --------------------------------------------------
  // Holding register
  // --------------------------------------------------

  logic     pushed;
  logic     popped;
  logic     hold_valid;
  payload_t hold_data;

  assign pushed = push_valid && push_ready;
  assign popped = pop_valid && pop_ready;

  // Room exists when the register is empty or is drained this cycle
  assign push_ready = pop_ready || !hold_valid;

  // A push always refills the register, even while the old beat leaves
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hold_valid <= 1'b0;
    end else if (pushed) begin
      hold_valid <= 1'b1;
    end else if (popped) begin
      hold_valid <= 1'b0;
    end
  end

  // Payload is qualified by hold_valid, so it needs no reset
  always_ff @(posedge clk) begin
    if (pushed) begin
      hold_data <= push_data;
    end
  end

  // --------------------------------------------------
  // Pop side
  // --------------------------------------------------

  // Both outputs leave from flops, which breaks the timing path
  // coming from the bypass stage upstream
  assign pop_valid = hold_valid;
  assign pop_data  = hold_data;

endmodule : flow_reg_fwd

//--- design/flow_reg_none.sv
/*
 * One-entry bypass flow register
 *   - Zero cut-through latency while the buffer is empty
 *   - Combinational paths from push_valid to pop_valid and
 *     from pop_ready to push_ready
 */

`timescale 1ns/1ps

module flow_reg_none #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,

  output logic     push_ready,
  input  logic     push_valid,
  input  payload_t push_data,

  input  logic     pop_ready,
  output logic     pop_valid,
  output payload_t pop_data
);

  // --------------------------------------------------
  // Side buffer control
  // --------------------------------------------------

  logic     pushed;
  logic     buf_load;
  logic     buf_unload;
  logic     buf_valid;
  payload_t buf_data;

  assign pushed = push_valid && push_ready;

  // A beat goes into the buffer when the pop side stalls,
  // or when the buffer already holds an older beat that must leave first
  assign buf_load   = pushed && (!pop_ready || buf_valid);
  assign buf_unload = pop_ready && buf_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      buf_valid <= 1'b0;
    end else begin
      buf_valid <= buf_load || (buf_valid && !buf_unload);
    end
  end

  // Contents are only looked at while buf_valid is set
  always_ff @(posedge clk) begin
    if (buf_load) begin
      buf_data <= push_data;
    end
  end

  // --------------------------------------------------
  // Pop side
  // --------------------------------------------------

  // The buffered beat is older than anything on the push side
  assign push_ready = pop_ready || !buf_valid;
  assign pop_valid  = push_valid || buf_valid;
  assign pop_data   = buf_valid ? buf_data : push_data;

endmodule : flow_reg_none

//--- design/stream_pipe_top.sv
/*
 * Stream pipe top level
 *   - Bypass flow register, transform stage, forward flow register
 *   - AXI4-Lite register block for control and counters
 *   - One cycle input to output latency
 */

`timescale 1ns/1ps

module stream_pipe_top
  import flow_pkg::*;
  import csr_pkg::*;
#(
  parameter type payload_t = stream_beat_t
) (
  input  logic      clk,
  input  logic      arst_n,

  // Stream input
  input  logic      in_valid,
  output logic      in_ready,
  input  payload_t  in_beat,

  // Stream output
  output logic      out_valid,
  input  logic      out_ready,
  output payload_t  out_beat,

  // Register port
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp
);

  // --------------------------------------------------
  // Internal links
  // --------------------------------------------------

  // Bypass register to transform
  logic                  byp_valid;
  logic                  byp_ready;
  payload_t              byp_beat;

  // Transform to forward register
  logic                  xf_valid;
  logic                  xf_ready;
  payload_t              xf_beat;

  // Register block and transform
  ctrl_t                 ctrl;
  logic [data_width-1:0] offset;
  logic [data_width-1:0] beat_count;
  logic [data_width-1:0] pkt_count;

  // --------------------------------------------------
  // Datapath chain
  // --------------------------------------------------

  // Absorbs one beat of back-pressure without adding latency
  flow_reg_none #(
    .payload_t (payload_t)
  ) u_flow_reg_none (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_ready (in_ready),
    .push_valid (in_valid),
    .push_data  (in_beat),
    .pop_ready  (byp_ready),
    .pop_valid  (byp_valid),
    .pop_data   (byp_beat)
  );

  stream_transform u_stream_transform (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (byp_valid),
    .in_ready   (byp_ready),
    .in_beat    (byp_beat),
    .out_valid  (xf_valid),
    .out_ready  (xf_ready),
    .out_beat   (xf_beat),
    .ctrl       (ctrl),
    .offset     (offset),
    .beat_count (beat_count),
    .pkt_count  (pkt_count)
  );

  // Registers the output so nothing combinational reaches out_valid
  flow_reg_fwd #(
    .payload_t (payload_t)
  ) u_flow_reg_fwd (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_ready (xf_ready),
    .push_valid (xf_valid),
    .push_data  (xf_beat),
    .pop_ready  (out_ready),
    .pop_valid  (out_valid),
    .pop_data   (out_beat)
  );

  // --------------------------------------------------
  // Register block
  // --------------------------------------------------

  csr_axil u_csr_axil (
    .clk        (clk),
    .arst_n     (arst_n),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .ctrl       (ctrl),
    .offset     (offset),
    .beat_count (beat_count),
    .pkt_count  (pkt_count)
  );

endmodule : stream_pipe_top

//--- design/stream_transform.sv
/*
 * Stream transform stage
 *   - Adds the programmed offset to each word while enabled
 *   - Counts transferred beats and packets
 *   - Zero latency on valid, ready and data
 */

`timescale 1ns/1ps

module stream_transform
  import flow_pkg::*;
  import csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,

  // Upstream side
  input  logic                  in_valid,
  output logic                  in_ready,
  input  stream_beat_t          in_beat,

  // Downstream side
  output logic                  out_valid,
  input  logic                  out_ready,
  output stream_beat_t          out_beat,

  // Control from the register block
  input  ctrl_t                 ctrl,
  input  logic [data_width-1:0] offset,

  // Statistics back to the register block
  output logic [data_width-1:0] beat_count,
  output logic [data_width-1:0] pkt_count
);

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------

  logic xfer;

  // Handshake passes straight through this stage
  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  // A beat counts only in the cycle it moves on downstream
  assign xfer = in_valid && out_ready;

  // The add wraps modulo 2**data_width, the last flag is never touched
  always_comb begin
    out_beat = in_beat;
    if (ctrl.enable) begin
      out_beat.data = in_beat.data + offset;
    end
  end

  // --------------------------------------------------
  // Beat and packet counters
  // --------------------------------------------------

  // Clear wins over an increment landing on the same edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_count <= '0;
      pkt_count  <= '0;
    end else if (ctrl.clear_counters) begin
      beat_count <= '0;
      pkt_count  <= '0;
    end else if (xfer) begin
      beat_count <= beat_count + 1'b1;
      // A packet is counted at its final beat
      if (in_beat.last) begin
        pkt_count <= pkt_count + 1'b1;
      end
    end
  end

endmodule : stream_transform

//--- test/tb_stream_pipe.sv
/*
 * Directed testbench for the stream pipe
 *   - AXI4-Lite write/read tasks and a stream packet task
 *   - Monitor with a queue of expected beats and an occupancy check
 *   - Watchdog, one line per test and a closing summary
 */

`timescale 1ns/1ps

module tb_stream_pipe
  import flow_pkg::*;
  import csr_pkg::*;
();

  // --------------------------------------------------
  // Run limits
  // --------------------------------------------------

  localparam int pass_beats   = 16;
  localparam int offset_beats = 16;
  localparam int bp_packets   = 3;
  localparam int bp_len       = 12;
  // Counter test sends packets of 5, 1 and 7 beats
  localparam int cnt_beats    = 13;
  localparam int total_beats  = pass_beats + offset_beats + bp_packets * bp_len + cnt_beats;
  // Twenty cycles per beat plus a margin for the register accesses
  localparam int watchdog_cycles = total_beats * 20 + 500;
  // Longest wait for any single handshake
  localparam int hs_limit = 200;

  // Expected beat together with the cycle it was accepted in
  typedef struct packed {
    stream_beat_t beat;
    logic [31:0]  cycle;
  } expect_t;

  logic         clk;
  logic         arst_n;
  logic         in_valid;
  logic         in_ready;
  stream_beat_t in_beat;
  logic         out_valid;
  logic         out_ready;
  stream_beat_t out_beat;
  axil_req_t    axil_req;
  axil_rsp_t    axil_rsp;

  logic [31:0]  data_rng;
  logic [31:0]  ready_rng;
  logic [31:0]  cycle_cnt = '0;
  logic [31:0]  off_model;
  logic         en_model;
  logic         random_ready;
  logic         check_latency;
  expect_t      exp_q[$];
  expect_t      mon_in;
  expect_t      mon_out;
  int           tb_beats;
  int           tb_pkts;
  int           errors;
  int           checks;
  int           tests_run;
  int           tests_failed;
  int           test_errors_start;
  string        test_name;

  stream_pipe_top #(
    .payload_t (stream_beat_t)
  ) uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp)
  );

  // --------------------------------------------------
  // Clock, random source, watchdog
  // --------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Sink readiness is random only while the back-pressure test runs
  // The mode is picked at the edge and the level driven just after it
  initial begin
    forever begin
      @(posedge clk);
      if (random_ready) begin
        ready_rng = xorshift32(ready_rng);
        #1;
        out_ready = ready_rng[7];
      end else begin
        #1;
        out_ready = 1'b1;
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog stopped the run after %0d cycles", watchdog_cycles);
    $display("TEST FAIL");
    $finish;
  end

  // --------------------------------------------------
  // Monitor
  // --------------------------------------------------

  // Sampled mid-cycle, so both handshakes are stable until the next edge
  always @(negedge clk) begin
    if (arst_n && in_valid && in_ready) begin
      mon_in.beat = in_beat;
      // Expected word is the input word plus the offset while enabled
      if (en_model) mon_in.beat.data = in_beat.data + off_model;
      mon_in.cycle = cycle_cnt;
      exp_q.push_back(mon_in);
      tb_beats++;
      if (in_beat.last) tb_pkts++;
    end
    if (arst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("output beat at %0t came out with no beat outstanding", $time);
        errors++;
      end else begin
        mon_out = exp_q.pop_front();
        checks++;
        assert (out_beat == mon_out.beat) else begin
          $display("mismatch at %0t: out data %h last %b, expected data %h last %b", $time,
                   out_beat.data, out_beat.last, mon_out.beat.data, mon_out.beat.last);
          errors++;
        end
        if (check_latency) begin
          checks++;
          assert (cycle_cnt - mon_out.cycle == 32'd1) else begin
            $display("mismatch at %0t: latency %0d cycles, expected 1", $time,
                     cycle_cnt - mon_out.cycle);
            errors++;
          end
        end
      end
    end
    // Accepted minus delivered never exceeds the two storage slots
    assert (exp_q.size() <= 2) else begin
      $display("mismatch at %0t: %0d beats held, expected at most 2", $time, exp_q.size());
      errors++;
    end
  end

  // --------------------------------------------------
  // Bus and stream tasks
  // --------------------------------------------------

  task automatic check_equal(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual == expected) else begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int waited;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.bready  = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!(axil_rsp.awready && axil_rsp.wready) && waited < hs_limit);
    if (!(axil_rsp.awready && axil_rsp.wready)) begin
      $display("write to address %h was never accepted", addr);
      errors++;
    end
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!axil_rsp.bvalid && waited < hs_limit);
    if (!axil_rsp.bvalid) begin
      $display("write to address %h got no response", addr);
      errors++;
    end
    resp = axil_rsp.bresp;
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int waited;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!axil_rsp.arready && waited < hs_limit);
    if (!axil_rsp.arready) begin
      $display("read of address %h was never accepted", addr);
      errors++;
    end
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!axil_rsp.rvalid && waited < hs_limit);
    if (!axil_rsp.rvalid) begin
      $display("read of address %h got no data", addr);
      errors++;
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_equal($sformatf("write response at %h", addr), {30'd0, resp}, {30'd0, exp_resp});
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_equal($sformatf("read data at %h", addr), data, exp_data);
    check_equal($sformatf("read response at %h", addr), {30'd0, resp}, {30'd0, exp_resp});
  endtask

  // Back-to-back beats, each held until the pipe takes it
  task automatic send_packet(input int len);
    int waited;
    for (int i = 0; i < len; i++) begin
      data_rng     = xorshift32(data_rng);
      in_valid     = 1'b1;
      in_beat.data = data_rng;
      in_beat.last = (i == len - 1);
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!in_ready && waited < hs_limit);
      if (!in_ready) begin
        $display("stream input stalled at beat %0d", i);
        errors++;
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < hs_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d beats never left the pipe", exp_q.size());
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_errors_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == test_errors_start) begin
      $display("%-14s ok", test_name);
    end else begin
      $display("%-14s failed with %0d errors", test_name, errors - test_errors_start);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  task automatic test_reset_regs();
    start_test("reset_regs");
    @(negedge clk);
    check_equal("out_valid after reset", {31'd0, out_valid}, 32'd0);
    check_equal("in_ready after reset", {31'd0, in_ready}, 32'd1);
    check_equal("bvalid after reset", {31'd0, axil_rsp.bvalid}, 32'd0);
    check_equal("rvalid after reset", {31'd0, axil_rsp.rvalid}, 32'd0);
    check_equal("arready after reset", {31'd0, axil_rsp.arready}, 32'd1);
    @(posedge clk);
    #1;
    read_expect(reg_ctrl, 0, resp_okay);
    read_expect(reg_offset, 0, resp_okay);
    read_expect(reg_beat_count, 0, resp_okay);
    read_expect(reg_pkt_count, 0, resp_okay);
    write_expect(reg_offset, 32'hA5A5_1234, resp_okay);
    read_expect(reg_offset, 32'hA5A5_1234, resp_okay);
    // Counters are read-only but still answer OKAY
    write_expect(reg_beat_count, 32'h55, resp_okay);
    read_expect(reg_beat_count, 0, resp_okay);
    write_expect(8'h10, 32'hFFFF_FFFF, resp_slverr);
    // An unmapped write leaves control and offset as they were
    read_expect(reg_ctrl, 0, resp_okay);
    read_expect(reg_offset, 32'hA5A5_1234, resp_okay);
    read_expect(8'h10, 0, resp_slverr);
    read_expect(8'h06, 0, resp_slverr);
    write_expect(reg_offset, 0, resp_okay);
    finish_test();
  endtask

  task automatic test_pass_through();
    start_test("pass_through");
    write_expect(reg_ctrl, 0, resp_okay);
    en_model      = 1'b0;
    check_latency = 1'b1;
    send_packet(pass_beats);
    wait_drain();
    check_latency = 1'b0;
    finish_test();
  endtask

  task automatic test_offset();
    start_test("offset");
    data_rng  = xorshift32(data_rng);
    off_model = data_rng;
    write_expect(reg_offset, off_model, resp_okay);
    write_expect(reg_ctrl, 32'h1, resp_okay);
    en_model = 1'b1;
    send_packet(offset_beats);
    wait_drain();
    finish_test();
  endtask

  task automatic test_back_pressure();
    start_test("back_pressure");
    random_ready = 1'b1;
    for (int p = 0; p < bp_packets; p++) begin
      send_packet(bp_len);
    end
    wait_drain();
    random_ready = 1'b0;
    finish_test();
  endtask

  task automatic test_counters();
    start_test("counters");
    // Clear with enable kept on, then count from zero
    write_expect(reg_ctrl, 32'h3, resp_okay);
    tb_beats = 0;
    tb_pkts  = 0;
    send_packet(5);
    send_packet(1);
    send_packet(7);
    wait_drain();
    read_expect(reg_beat_count, tb_beats, resp_okay);
    read_expect(reg_pkt_count, tb_pkts, resp_okay);
    write_expect(reg_ctrl, 32'h3, resp_okay);
    read_expect(reg_beat_count, 0, resp_okay);
    read_expect(reg_pkt_count, 0, resp_okay);
    read_expect(reg_ctrl, 32'h1, resp_okay);
    read_expect(reg_offset, off_model, resp_okay);
    finish_test();
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    arst_n        = 1'b0;
    in_valid      = 1'b0;
    in_beat       = '0;
    out_ready     = 1'b1;
    axil_req      = '0;
    data_rng      = 32'd60915;
    ready_rng     = xorshift32(32'd60915);
    off_model     = '0;
    en_model      = 1'b0;
    random_ready  = 1'b0;
    check_latency = 1'b0;
    tb_beats      = 0;
    tb_pkts       = 0;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset_regs();
    test_pass_through();
    test_offset();
    test_back_pressure();
    test_counters();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_stream_pipe

//--- vlog.f
design/flow_pkg.sv
design/csr_pkg.sv
design/flow_reg_none.sv
design/flow_reg_fwd.sv
design/stream_transform.sv
design/csr_axil.sv
design/stream_pipe_top.sv
test/tb_stream_pipe.sv
